/* include/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data word and byte address width
`define MIPS_WORD_W 32
// architectural integer registers, $0 included
`define MIPS_REG_CNT 32
`define MIPS_REG_IDX_W 5
// start of the text segment, first fetch after reset
`define MIPS_TEXT_START 32'h00400000

`endif

/* hdl/mips_isa_pkg.sv */
`include "mips_defs.svh"

package mips_isa_pkg;

   // machine word and the word-granular address on the memory ports
   typedef logic [`MIPS_WORD_W-1:0] word_t;
   typedef logic [`MIPS_WORD_W-3:0] word_addr_t;

   // instruction fields
   typedef logic [`MIPS_REG_IDX_W-1:0] reg_idx_t;
   typedef logic [15:0] imm16_t;
   typedef logic [4:0] shamt_t;

   // one enable bit per byte lane
   typedef logic [3:0] be_t;

   localparam int unsigned REG_CNT = `MIPS_REG_CNT;
   localparam word_t TEXT_START = `MIPS_TEXT_START;

   // primary opcodes, bits 31:26
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_t;

   // funct codes under OP_SPECIAL, bits 5:0
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_t;

endpackage

/* hdl/mips_ctrl_pkg.sv */
`include "mips_defs.svh"

package mips_ctrl_pkg;

   // ALU operation, zero is add so a cleared stage register is harmless
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_t;

   // source of the register file write data in WB
   typedef enum logic {
      WB_ALU,
      WB_LOAD
   } wb_sel_t;

   // fetch runs until a syscall is decoded, then stays stopped
   typedef enum logic {
      FETCH_RUN,
      FETCH_STOP
   } fetch_state_t;

endpackage

/* hdl/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
(
   input  mips_isa_pkg::word_t    op_a,
   input  mips_isa_pkg::word_t    op_b,
   input  mips_isa_pkg::shamt_t   shamt,
   input  mips_ctrl_pkg::alu_op_t alu_op,
   output mips_isa_pkg::word_t    result
);

   import mips_ctrl_pkg::*;

   always_comb
   begin
      case (alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_NOR: result = ~(op_a | op_b);
         // signed compare, result is 0 or 1
         ALU_SLT: result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         // shifts move rt by the instruction's shamt field
         ALU_SLL: result = op_b << shamt;
         ALU_SRL: result = op_b >> shamt;
         ALU_SRA: result = $signed(op_b) >>> shamt;
         // immediate into the upper half, low half cleared
         ALU_LUI: result = {op_b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

endmodule

/* hdl/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile
(
   input  logic                   clk,
   input  logic                   rst_b,
   input  mips_isa_pkg::reg_idx_t rs_idx,
   input  mips_isa_pkg::reg_idx_t rt_idx,
   output mips_isa_pkg::word_t    rs_data,
   output mips_isa_pkg::word_t    rt_data,
   input  logic                   wr_en,
   input  mips_isa_pkg::reg_idx_t wr_reg,
   input  mips_isa_pkg::word_t    wr_data
);

   import mips_isa_pkg::*;

   // $0 has no storage
   word_t regs [1:REG_CNT-1];

   // write-through, a same-cycle write is seen by the read
   function automatic word_t read_port(input reg_idx_t idx);
      word_t val;
      if (idx == '0)
         val = '0;
      else if (wr_en && (wr_reg == idx))
         val = wr_data;
      else
         val = regs[idx];
      return val;
   endfunction

   always_comb
   begin
      rs_data = read_port(rs_idx);
      rt_data = read_port(rt_idx);
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < REG_CNT; i++)
            regs[i] <= '0;
      end
      else if (wr_en && (wr_reg != '0))
         regs[wr_reg] <= wr_data;
   end

endmodule

/* hdl/mips_fetch.sv */
`timescale 1ns/1ps

module mips_fetch
(
   input  logic                     clk,
   input  logic                     rst_b,
   input  logic                     is_syscall,
   input  mips_isa_pkg::word_t      inst,
   output mips_isa_pkg::word_addr_t inst_addr,
   output mips_isa_pkg::word_t      id_inst
);

   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   fetch_state_t state;
   word_t        pc;
   logic         run;

   // a syscall sitting in ID already blocks this cycle's fetch
   assign run = (state == FETCH_RUN) && !is_syscall;

   // memory is word addressed, drop the byte offset
   assign inst_addr = pc[`MIPS_WORD_W-1:2];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         state   <= FETCH_RUN;
         pc      <= TEXT_START;
         id_inst <= '0;
      end
      else
      begin
         // stopped is terminal, only reset leaves it
         if (is_syscall)
            state <= FETCH_STOP;
         if (run)
            pc <= pc + 32'd4;
         // all-zero word decodes as sll $0,$0,0
         id_inst <= run ? inst : '0;
      end
   end

endmodule

/* hdl/mips_decode.sv */
`timescale 1ns/1ps

module mips_decode
(
   input  mips_isa_pkg::word_t    id_inst,
   output mips_isa_pkg::reg_idx_t rs_idx,
   output mips_isa_pkg::reg_idx_t rt_idx,
   output mips_isa_pkg::word_t    imm,
   output mips_isa_pkg::shamt_t   shamt,
   output mips_ctrl_pkg::alu_op_t alu_op,
   output logic                   alu_src_imm,
   output mips_isa_pkg::reg_idx_t dst_reg,
   output logic                   reg_we,
   output logic                   mem_read,
   output logic                   mem_write,
   output logic                   is_syscall
);

   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   opcode_t  op;
   funct_t   fn;
   imm16_t   imm16;
   reg_idx_t rd_idx;
   logic     we;
   logic     dst_rd;

   // field split
   assign op     = opcode_t'(id_inst[31:26]);
   assign rs_idx = id_inst[25:21];
   assign rt_idx = id_inst[20:16];
   assign rd_idx = id_inst[15:11];
   assign shamt  = id_inst[10:6];
   assign fn     = funct_t'(id_inst[5:0]);
   assign imm16  = id_inst[15:0];

   // R-type writes rd, I-type writes rt
   assign dst_reg = dst_rd ? rd_idx : rt_idx;
   // $0 is never written
   assign reg_we = we && (dst_reg != '0);

   always_comb
   begin
      // default is a no-op with sign-extended immediate
      imm         = {{16{imm16[15]}}, imm16};
      alu_op      = ALU_ADD;
      alu_src_imm = 1'b0;
      we          = 1'b0;
      dst_rd      = 1'b0;
      mem_read    = 1'b0;
      mem_write   = 1'b0;
      is_syscall  = 1'b0;
      case (op)
         OP_SPECIAL:
         begin
            we     = 1'b1;
            dst_rd = 1'b1;
            case (fn)
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SYSCALL:
               begin
                  we         = 1'b0;
                  is_syscall = 1'b1;
               end
               // unknown funct runs as a no-op
               default:
               begin
                  we     = 1'b0;
                  dst_rd = 1'b0;
               end
            endcase
         end
         OP_ADDIU:
         begin
            alu_src_imm = 1'b1;
            we          = 1'b1;
         end
         // logical immediates are zero extended
         OP_ANDI, OP_ORI, OP_XORI:
         begin
            imm         = {16'h0000, imm16};
            alu_src_imm = 1'b1;
            we          = 1'b1;
            alu_op      = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR : ALU_XOR;
         end
         OP_LUI:
         begin
            alu_op      = ALU_LUI;
            alu_src_imm = 1'b1;
            we          = 1'b1;
         end
         // address is rs plus sign-extended offset
         OP_LW:
         begin
            alu_src_imm = 1'b1;
            we          = 1'b1;
            mem_read    = 1'b1;
         end
         OP_SW:
         begin
            alu_src_imm = 1'b1;
            mem_write   = 1'b1;
         end
         default:
         begin
            we = 1'b0;
         end
      endcase
   end

endmodule

/* hdl/mips_execute.sv */
`timescale 1ns/1ps

module mips_execute
(
   input  logic                   clk,
   input  logic                   rst_b,
   input  mips_isa_pkg::word_t    rs_data,
   input  mips_isa_pkg::word_t    rt_data,
   input  mips_isa_pkg::word_t    imm,
   input  mips_isa_pkg::shamt_t   shamt,
   input  mips_ctrl_pkg::alu_op_t alu_op,
   input  logic                   alu_src_imm,
   input  mips_isa_pkg::reg_idx_t dst_reg,
   input  logic                   reg_we,
   input  logic                   mem_read,
   input  logic                   mem_write,
   input  logic                   is_syscall,
   output mips_isa_pkg::word_t    ex_result,
   output mips_isa_pkg::word_t    ex_store_data,
   output mips_isa_pkg::reg_idx_t ex_dst_reg,
   output logic                   ex_reg_we,
   output logic                   ex_mem_read,
   output logic                   ex_mem_write,
   output logic                   ex_syscall
);

   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   // ID/EX stage register
   word_t    idex_rs;
   word_t    idex_rt;
   word_t    idex_imm;
   shamt_t   idex_shamt;
   alu_op_t  idex_alu_op;
   logic     idex_src_imm;
   reg_idx_t idex_dst;
   logic     idex_we;
   logic     idex_rd;
   logic     idex_wr;
   logic     idex_sys;

   word_t    op_b;
   word_t    alu_result;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         idex_rs      <= '0;
         idex_rt      <= '0;
         idex_imm     <= '0;
         idex_shamt   <= '0;
         idex_alu_op  <= ALU_ADD;
         idex_src_imm <= 1'b0;
         idex_dst     <= '0;
         idex_we      <= 1'b0;
         idex_rd      <= 1'b0;
         idex_wr      <= 1'b0;
         idex_sys     <= 1'b0;
      end
      else
      begin
         idex_rs      <= rs_data;
         idex_rt      <= rt_data;
         idex_imm     <= imm;
         idex_shamt   <= shamt;
         idex_alu_op  <= alu_op;
         idex_src_imm <= alu_src_imm;
         idex_dst     <= dst_reg;
         idex_we      <= reg_we;
         idex_rd      <= mem_read;
         idex_wr      <= mem_write;
         idex_sys     <= is_syscall;
      end
   end

   // second operand is rt or the extended immediate
   assign op_b = idex_src_imm ? idex_imm : idex_rt;

   mips_alu u_alu
   (
      .op_a   (idex_rs),
      .op_b   (op_b),
      .shamt  (idex_shamt),
      .alu_op (idex_alu_op),
      .result (alu_result)
   );

   // EX/MEM stage register, rt travels on as store data
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         ex_result     <= '0;
         ex_store_data <= '0;
         ex_dst_reg    <= '0;
         ex_reg_we     <= 1'b0;
         ex_mem_read   <= 1'b0;
         ex_mem_write  <= 1'b0;
         ex_syscall    <= 1'b0;
      end
      else
      begin
         ex_result     <= alu_result;
         ex_store_data <= idex_rt;
         ex_dst_reg    <= idex_dst;
         ex_reg_we     <= idex_we;
         ex_mem_read   <= idex_rd;
         ex_mem_write  <= idex_wr;
         ex_syscall    <= idex_sys;
      end
   end

endmodule

/* hdl/mips_mem_wb.sv */
`timescale 1ns/1ps

module mips_mem_wb
(
   input  logic                     clk,
   input  logic                     rst_b,
   input  mips_isa_pkg::word_t      ex_result,
   input  mips_isa_pkg::word_t      ex_store_data,
   input  mips_isa_pkg::reg_idx_t   ex_dst_reg,
   input  logic                     ex_reg_we,
   input  logic                     ex_mem_read,
   input  logic                     ex_mem_write,
   input  logic                     ex_syscall,
   input  mips_isa_pkg::word_t      mem_data_out,
   output mips_isa_pkg::word_addr_t mem_addr,
   output mips_isa_pkg::word_t      mem_data_in,
   output mips_isa_pkg::be_t        mem_write_en,
   output logic                     wr_en,
   output mips_isa_pkg::reg_idx_t   wr_reg,
   output mips_isa_pkg::word_t      wr_data,
   output logic                     halted
);

   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   wb_sel_t mem_sel;
   wb_sel_t wb_sel;
   word_t   wb_alu;
   word_t   wb_load;
   logic    wb_syscall;

   // word accesses only so the mask is all lanes or none
   assign mem_addr     = ex_result[`MIPS_WORD_W-1:2];
   assign mem_data_in  = ex_store_data;
   assign mem_write_en = ex_mem_write ? 4'b1111 : 4'b0000;

   assign mem_sel = ex_mem_read ? WB_LOAD : WB_ALU;

   // MEM/WB stage register
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         wb_sel     <= WB_ALU;
         wb_alu     <= '0;
         wb_load    <= '0;
         wr_reg     <= '0;
         wr_en      <= 1'b0;
         wb_syscall <= 1'b0;
      end
      else
      begin
         wb_sel     <= mem_sel;
         wb_alu     <= ex_result;
         wb_load    <= mem_data_out;
         wr_reg     <= ex_dst_reg;
         wr_en      <= ex_reg_we;
         wb_syscall <= ex_syscall;
      end
   end

   assign wr_data = (wb_sel == WB_LOAD) ? wb_load : wb_alu;

   // sticky flag that rises on the edge where the syscall leaves WB
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         halted <= 1'b0;
      else if (wb_syscall)
         halted <= 1'b1;
   end

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/1ps

module mips_core
(
   input  logic                     clk,
   input  logic                     rst_b,
   output mips_isa_pkg::word_addr_t inst_addr,
   input  mips_isa_pkg::word_t      inst,
   output mips_isa_pkg::word_addr_t mem_addr,
   output mips_isa_pkg::word_t      mem_data_in,
   input  mips_isa_pkg::word_t      mem_data_out,
   output mips_isa_pkg::be_t        mem_write_en,
   output logic                     halted
);

   // IF/ID
   mips_isa_pkg::word_t     id_inst;
   logic                    is_syscall;

   // ID outputs
   mips_isa_pkg::reg_idx_t  rs_idx;
   mips_isa_pkg::reg_idx_t  rt_idx;
   mips_isa_pkg::word_t     rs_data;
   mips_isa_pkg::word_t     rt_data;
   mips_isa_pkg::word_t     imm;
   mips_isa_pkg::shamt_t    shamt;
   mips_ctrl_pkg::alu_op_t  alu_op;
   logic                    alu_src_imm;
   mips_isa_pkg::reg_idx_t  dst_reg;
   logic                    reg_we;
   logic                    mem_read;
   logic                    mem_write;

   // EX/MEM
   mips_isa_pkg::word_t     ex_result;
   mips_isa_pkg::word_t     ex_store_data;
   mips_isa_pkg::reg_idx_t  ex_dst_reg;
   logic                    ex_reg_we;
   logic                    ex_mem_read;
   logic                    ex_mem_write;
   logic                    ex_syscall;

   // register file write port, driven from WB
   logic                    wr_en;
   mips_isa_pkg::reg_idx_t  wr_reg;
   mips_isa_pkg::word_t     wr_data;

   mips_fetch u_fetch
   (
      .clk        (clk),
      .rst_b      (rst_b),
      .is_syscall (is_syscall),
      .inst       (inst),
      .inst_addr  (inst_addr),
      .id_inst    (id_inst)
   );

   mips_decode u_decode
   (
      .id_inst     (id_inst),
      .rs_idx      (rs_idx),
      .rt_idx      (rt_idx),
      .imm         (imm),
      .shamt       (shamt),
      .alu_op      (alu_op),
      .alu_src_imm (alu_src_imm),
      .dst_reg     (dst_reg),
      .reg_we      (reg_we),
      .mem_read    (mem_read),
      .mem_write   (mem_write),
      .is_syscall  (is_syscall)
   );

   mips_regfile u_regfile
   (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs_idx),
      .rt_idx  (rt_idx),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wr_en   (wr_en),
      .wr_reg  (wr_reg),
      .wr_data (wr_data)
   );

   mips_execute u_execute
   (
      .clk           (clk),
      .rst_b         (rst_b),
      .rs_data       (rs_data),
      .rt_data       (rt_data),
      .imm           (imm),
      .shamt         (shamt),
      .alu_op        (alu_op),
      .alu_src_imm   (alu_src_imm),
      .dst_reg       (dst_reg),
      .reg_we        (reg_we),
      .mem_read      (mem_read),
      .mem_write     (mem_write),
      .is_syscall    (is_syscall),
      .ex_result     (ex_result),
      .ex_store_data (ex_store_data),
      .ex_dst_reg    (ex_dst_reg),
      .ex_reg_we     (ex_reg_we),
      .ex_mem_read   (ex_mem_read),
      .ex_mem_write  (ex_mem_write),
      .ex_syscall    (ex_syscall)
   );

   mips_mem_wb u_mem_wb
   (
      .clk           (clk),
      .rst_b         (rst_b),
      .ex_result     (ex_result),
      .ex_store_data (ex_store_data),
      .ex_dst_reg    (ex_dst_reg),
      .ex_reg_we     (ex_reg_we),
      .ex_mem_read   (ex_mem_read),
      .ex_mem_write  (ex_mem_write),
      .ex_syscall    (ex_syscall),
      .mem_data_out  (mem_data_out),
      .mem_addr      (mem_addr),
      .mem_data_in   (mem_data_in),
      .mem_write_en  (mem_write_en),
      .wr_en         (wr_en),
      .wr_reg        (wr_reg),
      .wr_data       (wr_data),
      .halted        (halted)
   );

endmodule

/* test/mips_core_sva.sv */
`timescale 1ns/1ps

module mips_core_sva
(
   input logic                     clk,
   input logic                     rst_b,
   input mips_isa_pkg::word_addr_t inst_addr,
   input mips_isa_pkg::be_t        mem_write_en,
   input logic                     halted
);

   // word stores only, every lane or none
   full_mask: assert property (@(posedge clk) disable iff (!rst_b)
      (mem_write_en == 4'b0000) || (mem_write_en == 4'b1111))
      else $error("mem_write_en has a partial mask %b", mem_write_en);

   // halted is sticky until reset
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted)
      else $error("halted fell without reset");

   // drained pipeline, nothing left to store
   halt_no_store: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> (mem_write_en == 4'b0000))
      else $error("memory write while halted");

   // fetch is frozen once halted
   halt_pc_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else $error("inst_addr moved while halted");

endmodule

bind mips_core mips_core_sva u_sva
(
   .clk          (clk),
   .rst_b        (rst_b),
   .inst_addr    (inst_addr),
   .mem_write_en (mem_write_en),
   .halted       (halted)
);

/* test/mips_core_tb.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_tb;

   import mips_isa_pkg::*;

   localparam int unsigned SEED = 32'hb37822d7;
   // word index of the first fetch
   localparam int TEXT_IDX   = `MIPS_TEXT_START / 4;
   localparam int IMEM_WORDS = 1024;
   localparam int DMEM_WORDS = 1024;
   // word indexes of the random data area and the register dump area
   localparam int DATA_BASE  = 256;
   localparam int DUMP_BASE  = 768;
   localparam int N_INST     = 200;
   localparam int RUN_LIMIT  = 4000;
   localparam int N_TESTS    = 6;
   localparam int T_RESET    = 0;
   localparam int T_FETCH    = 1;
   localparam int T_STORE    = 2;
   localparam int T_LOAD     = 3;
   localparam int T_DUMP     = 4;
   localparam int T_HALT     = 5;

   logic       clk;
   logic       rst_b;
   word_addr_t inst_addr;
   word_t      inst = '0;
   word_addr_t mem_addr;
   word_t      mem_data_in;
   word_t      mem_data_out = '0;
   be_t        mem_write_en;
   logic       halted;

   // program and the memory seen by the DUT
   word_t imem [0:IMEM_WORDS-1];
   word_t dmem [0:DMEM_WORDS-1];
   int    prog_len;
   int    sys_idx;
   int    last_wr [0:31];

   // architectural model state and its ordered store list
   word_t      mregs [0:31];
   word_t      mmem [0:DMEM_WORDS-1];
   word_addr_t exp_addr [$];
   word_t      exp_data [$];
   bit         exp_load [$];

   int          test_chk [0:N_TESTS-1];
   int          test_err [0:N_TESTS-1];
   string       tname [0:N_TESTS-1] = '{"reset", "fetch_order", "store_trace", "loads",
                                        "final_dump", "halt"};
   bit          mon_on = 1'b0;
   int          cyc;
   int          wait_cnt;
   int          tot_chk;
   int          tot_err;

   mips_core u_dut
   (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_data_out (mem_data_out),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_value(input int test, input string sig, input word_t got,
                               input word_t exp);
      $display("[FAIL] t=%0t %s got %h expected %h", $time, sig, got, exp);
      test_err[test]++;
   endtask

   task automatic report_text(input int test, input string msg);
      $display("error at t=%0t: %s", $time, msg);
      test_err[test]++;
   endtask

   task automatic emit(input word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   // no forwarding so a reader trails its writer by three slots
   task automatic pad_for(input int src);
      while (prog_len < last_wr[src] + 3)
         emit('0);
   endtask

   task automatic gen_program();
      logic [5:0]  r_fn [0:9];
      logic [5:0]  i_op [0:4];
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [15:0] off;
      int          kind;
      int          wr;
      // the first three functs are shifts and the last opcode is lui
      r_fn = '{6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a};
      i_op = '{6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
      prog_len = 0;
      for (int r = 0; r < 32; r++)
         last_wr[r] = -8;
      for (int i = 0; i < N_INST; i++)
      begin
         kind = int'($urandom_range(0, 17));
         rs   = 5'($urandom);
         rt   = 5'($urandom);
         rd   = 5'($urandom);
         if (kind < 10)
         begin
            // shifts take only rt
            if (kind < 3)
               rs = 5'd0;
            pad_for(int'(rs));
            pad_for(int'(rt));
            emit({6'h00, rs, rt, rd, 5'($urandom), r_fn[kind]});
            wr = int'(rd);
         end
         else if (kind < 15)
         begin
            if (kind == 14)
               rs = 5'd0;
            pad_for(int'(rs));
            emit({i_op[kind-10], rs, rt, 16'($urandom)});
            wr = int'(rt);
         end
         else
         begin
            // word aligned offsets from $0 into the data area
            off = 16'((DATA_BASE + int'($urandom_range(0, 255))) * 4);
            if (kind == 15)
            begin
               emit({6'h23, 5'd0, rt, off});
               wr = int'(rt);
            end
            else
            begin
               pad_for(int'(rt));
               emit({6'h2b, 5'd0, rt, off});
               wr = 0;
            end
         end
         if (wr != 0)
            last_wr[wr] = prog_len - 1;
      end
      // dump $1..$31 before the syscall and junk that must never run after it
      for (int r = 1; r < 32; r++)
      begin
         pad_for(r);
         emit({6'h2b, 5'd0, 5'(r), 16'((DUMP_BASE + r) * 4)});
      end
      sys_idx = prog_len;
      emit(32'h0000000c);
      for (int f = 0; f < 16; f++)
         emit($urandom);
   endtask

   // architectural interpreter stepping one instruction at a time until syscall
   task automatic run_model();
      word_t      w;
      word_t      a;
      word_t      b;
      word_t      res;
      word_t      sext;
      word_t      ea;
      logic [5:0] op;
      logic [5:0] fn;
      logic [4:0] sh;
      int         rt;
      int         pc_i;
      int         dst;
      bit         done;
      bit         ld;
      bit         from_load [0:31];
      for (int r = 0; r < 32; r++)
      begin
         mregs[r]     = '0;
         from_load[r] = 1'b0;
      end
      for (int i = 0; i < DMEM_WORDS; i++)
         mmem[i] = dmem[i];
      pc_i = 0;
      done = 1'b0;
      while (!done && pc_i < IMEM_WORDS)
      begin
         w    = imem[pc_i];
         pc_i++;
         op   = w[31:26];
         fn   = w[5:0];
         sh   = w[10:6];
         rt   = int'(w[20:16]);
         a    = mregs[int'(w[25:21])];
         b    = mregs[rt];
         sext = {{16{w[15]}}, w[15:0]};
         ea   = a + sext;
         dst  = 0;
         ld   = 1'b0;
         res  = '0;
         case (op)
            6'h00:
            begin
               dst = int'(w[15:11]);
               case (fn)
                  6'h00: res = b << sh;
                  6'h02: res = b >> sh;
                  6'h03: res = $signed(b) >>> sh;
                  6'h21: res = a + b;
                  6'h23: res = a - b;
                  6'h24: res = a & b;
                  6'h25: res = a | b;
                  6'h26: res = a ^ b;
                  6'h27: res = ~(a | b);
                  6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  6'h0c:
                  begin
                     done = 1'b1;
                     dst  = 0;
                  end
                  default: dst = 0;
               endcase
            end
            6'h09:
            begin
               dst = rt;
               res = a + sext;
            end
            // logical immediates zero extend
            6'h0c:
            begin
               dst = rt;
               res = a & {16'h0000, w[15:0]};
            end
            6'h0d:
            begin
               dst = rt;
               res = a | {16'h0000, w[15:0]};
            end
            6'h0e:
            begin
               dst = rt;
               res = a ^ {16'h0000, w[15:0]};
            end
            6'h0f:
            begin
               dst = rt;
               res = {w[15:0], 16'h0000};
            end
            6'h23:
            begin
               dst = rt;
               res = mmem[ea[11:2]];
               ld  = 1'b1;
            end
            6'h2b:
            begin
               mmem[ea[11:2]] = b;
               exp_addr.push_back(ea[31:2]);
               exp_data.push_back(b);
               exp_load.push_back(from_load[rt]);
            end
            default:
            begin
               dst = 0;
            end
         endcase
         if (dst != 0)
         begin
            mregs[dst]     = res;
            from_load[dst] = ld;
         end
      end
   endtask

   task automatic check_reset_outputs();
      test_chk[T_RESET]++;
      if (int'(inst_addr) != TEXT_IDX)
         report_value(T_RESET, "inst_addr", word_t'(inst_addr), word_t'(TEXT_IDX));
      if (halted !== 1'b0)
         report_value(T_RESET, "halted", word_t'(halted), '0);
      if (mem_write_en !== 4'b0000)
         report_value(T_RESET, "mem_write_en", word_t'(mem_write_en), '0);
   endtask

   // checks for one pipeline cycle where cycle 0 presents instruction 0
   task automatic watch_cycle();
      word_addr_t ea;
      word_t      ed;
      bit         ld;
      bit         exp_halt;
      cyc++;
      exp_halt = (cyc >= sys_idx + 5);
      if (cyc <= sys_idx)
      begin
         test_chk[T_FETCH]++;
         if (int'(inst_addr) != TEXT_IDX + cyc)
            report_value(T_FETCH, "inst_addr", word_t'(inst_addr), word_t'(TEXT_IDX + cyc));
      end
      else
      begin
         // frozen just past the syscall
         test_chk[T_HALT]++;
         if (int'(inst_addr) != TEXT_IDX + sys_idx + 1)
            report_value(T_HALT, "inst_addr", word_t'(inst_addr),
                         word_t'(TEXT_IDX + sys_idx + 1));
      end
      test_chk[T_HALT]++;
      if (halted !== exp_halt)
         report_value(T_HALT, "halted", word_t'(halted), word_t'(exp_halt));
      if (halted && mem_write_en != 4'b0000)
         report_text(T_HALT, "memory write after halted rose");
      if (mem_write_en != 4'b0000)
      begin
         test_chk[T_STORE]++;
         if (mem_write_en != 4'b1111)
            report_text(T_STORE, "store with a partial byte mask");
         else if (exp_addr.size() == 0)
            report_text(T_STORE, "store beyond the end of the expected trace");
         else
         begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            ld = exp_load.pop_front();
            if (mem_addr !== ea)
               report_value(T_STORE, "mem_addr", word_t'(mem_addr), word_t'(ea));
            if (ld)
               test_chk[T_LOAD]++;
            if (mem_data_in !== ed)
               report_value(ld ? T_LOAD : T_STORE, "mem_data_in", mem_data_in, ed);
         end
      end
   endtask

   function automatic word_t fetch_word(input word_addr_t addr);
      int idx;
      idx = int'(addr) - TEXT_IDX;
      if (idx >= 0 && idx < IMEM_WORDS)
         return imem[idx];
      return '0;
   endfunction

   // outputs are sampled mid-cycle and inputs driven for the next rising edge
   always @(negedge clk)
   begin
      if (mon_on)
         watch_cycle();
      if (mem_write_en == 4'b1111 && int'(mem_addr) < DMEM_WORDS)
         dmem[mem_addr[9:0]] = mem_data_in;
      inst = fetch_word(inst_addr);
      if (int'(mem_addr) < DMEM_WORDS)
         mem_data_out = dmem[mem_addr[9:0]];
      else
         mem_data_out = '0;
   end

   initial
   begin
      rst_b = 1'b0;
      void'($urandom(SEED));
      cyc   = 0;
      for (int t = 0; t < N_TESTS; t++)
      begin
         test_chk[t] = 0;
         test_err[t] = 0;
      end
      for (int i = 0; i < IMEM_WORDS; i++)
         imem[i] = '0;
      // preload every data word with random contents
      for (int i = 0; i < DMEM_WORDS; i++)
         dmem[i] = $urandom;
      gen_program();
      run_model();
      $display("program: %0d words, syscall at %0d, %0d stores expected",
               prog_len, sys_idx, exp_addr.size());

      for (int i = 0; i < 5; i++)
      begin
         @(posedge clk);
         @(negedge clk);
         check_reset_outputs();
      end
      rst_b = 1'b1;
      #1;
      check_reset_outputs();
      @(posedge clk);
      mon_on = 1'b1;

      wait_cnt = 0;
      while (!halted && wait_cnt < RUN_LIMIT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!halted)
      begin
         $display("timeout: halted did not rise within %0d cycles", RUN_LIMIT);
         $display("=== FAIL ===");
         $finish;
      end
      else
      begin
         // watch the frozen state for a few more cycles
         repeat (8) @(negedge clk);
         @(posedge clk);
         mon_on = 1'b0;
         if (exp_addr.size() != 0)
            report_text(T_STORE, $sformatf("%0d expected stores never appeared",
                                           exp_addr.size()));
         for (int r = 1; r < 32; r++)
         begin
            test_chk[T_DUMP]++;
            if (dmem[DUMP_BASE + r] !== mregs[r])
               report_value(T_DUMP, $sformatf("dump of $%0d", r), dmem[DUMP_BASE + r],
                            mregs[r]);
         end
         tot_chk = 0;
         tot_err = 0;
         for (int t = 0; t < N_TESTS; t++)
         begin
            $display("test %s: %0d checks, %0d errors, %s", tname[t], test_chk[t],
                     test_err[t], (test_err[t] == 0) ? "ok" : "bad");
            tot_chk += test_chk[t];
            tot_err += test_err[t];
         end
         $display("total: %0d tests, %0d checks, %0d errors", N_TESTS, tot_chk, tot_err);
         if (tot_err == 0)
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
         $finish;
      end
   end

endmodule

/* filelist.f */
+incdir+include
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_fetch.sv
hdl/mips_decode.sv
hdl/mips_execute.sv
hdl/mips_mem_wb.sv
hdl/mips_core.sv
test/mips_core_sva.sv
test/mips_core_tb.sv

/* Makefile */
TOP := mips_core_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

# the run's own status is ignored, the log decides pass or fail
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "=== FAIL ===" $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
